// ==== all.f ====
+incdir+include
hw/sat_types_pkg.sv
hw/trail_ctrl_pkg.sv
hw/trail_store.sv
hw/var_table.sv
hw/backtrack_walker.sv
hw/var_table_arbiter.sv
hw/trail_manager.sv
tests/trail_manager_tb.sv

// ==== hw/backtrack_walker.sv ====
/*
 * Iterative backtrack FSM
 * Walks the trail newest to oldest, one entry per cycle
 * Streams removed entries, clears their table slots, commits height and level
 */
`timescale 1ns/1ns
`default_nettype none

module backtrack_walker (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               backtrack_en,
    input  logic [sat_types_pkg::LVL_W-1:0]    backtrack_to_level,
    input  logic [sat_types_pkg::LVL_W-1:0]    height,
    input  sat_types_pkg::trail_entry_t        peek_entry,
    output logic [sat_types_pkg::LVL_W-1:0]    peek_idx,
    output logic                               backtrack_valid,
    output logic [sat_types_pkg::VAR_W-1:0]    backtrack_var,
    output logic                               backtrack_value,
    output logic                               backtrack_is_decision,
    output logic                               backtrack_done,
    output trail_ctrl_pkg::vt_write_t          clear_write,
    output trail_ctrl_pkg::bt_commit_t         commit,
    output logic                               walker_busy
);

    trail_ctrl_pkg::bt_state_t       state_q;
    logic [sat_types_pkg::LVL_W-1:0] idx_q;
    logic [sat_types_pkg::LVL_W-1:0] target_q;
    logic                            remove;

    // Entry just below the walk index
    assign peek_idx = (idx_q != '0) ? idx_q - 1'b1 : '0;

    assign remove = (state_q == trail_ctrl_pkg::WALK)
                    && (idx_q != '0)
                    && (peek_entry.level > target_q);

    // Start cycle counts as busy so no push slips past the sampled height
    assign walker_busy = (state_q != trail_ctrl_pkg::IDLE) || backtrack_en;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= trail_ctrl_pkg::IDLE;
            idx_q <= '0;
            target_q <= '0;
        end else begin
            case (state_q)
                trail_ctrl_pkg::IDLE: begin
                    if (backtrack_en) begin
                        idx_q <= height;
                        target_q <= backtrack_to_level;
                        state_q <= trail_ctrl_pkg::WALK;
                    end
                end
                trail_ctrl_pkg::WALK: begin
                    if (remove) begin
                        idx_q <= peek_idx;
                    end else begin
                        state_q <= trail_ctrl_pkg::COMMIT;
                    end
                end
                default: begin
                    state_q <= trail_ctrl_pkg::IDLE;
                end
            endcase
        end
    end

    // Removed entry stream
    assign backtrack_valid = remove;
    assign backtrack_var = peek_entry.variable;
    assign backtrack_value = peek_entry.value;
    assign backtrack_is_decision = peek_entry.is_decision;
    assign backtrack_done = (state_q == trail_ctrl_pkg::COMMIT);

    always_comb begin
        clear_write.valid = remove;
        clear_write.variable = peek_entry.variable;
        clear_write.level = '0;
        clear_write.value = 1'b0;
        clear_write.index = '1;
    end

    // Walk index is the new height
    always_comb begin
        commit.valid = backtrack_done;
        commit.height = idx_q;
        commit.level = target_q;
    end

endmodule

`default_nettype wire

// ==== hw/sat_types_pkg.sv ====
/*
 * Solver-domain sizes for the assignment trail
 * Trail entry struct and push request struct
 */
`default_nettype none

package sat_types_pkg;

    // Trail depth and highest variable ID
    // Variable IDs run from 1 to MAX_VARS
    localparam int MAX_VARS = 256;
    localparam int VAR_W = 32;
    // Decision level, trail index and height all use this width
    localparam int LVL_W = 16;
    localparam int REASON_W = 16;

    // Address widths of the trail RAM and of the variable tables
    localparam int TRAIL_AW = $clog2(MAX_VARS);
    localparam int VT_AW = $clog2(MAX_VARS + 1);

    // Reason returned for a trail read at or above the height
    localparam logic [REASON_W-1:0] NO_REASON = '1;

    // One assignment on the trail, 66 bits
    typedef struct packed {
        logic [VAR_W-1:0]    variable;
        logic                value;
        logic [LVL_W-1:0]    level;
        logic                is_decision;
        logic [REASON_W-1:0] reason;
    } trail_entry_t;

    typedef struct packed {
        logic         valid;
        trail_entry_t entry;
    } push_req_t;

endpackage

`default_nettype wire

// ==== hw/trail_ctrl_pkg.sv ====
/*
 * Control-side types of the trail manager
 * Walker state enum, variable table write request, commit record
 */
`default_nettype none

package trail_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE,
        WALK,
        COMMIT
    } bt_state_t;

    // Clear requests carry level 0, value 0 and an all-ones index
    typedef struct packed {
        logic                             valid;
        logic [sat_types_pkg::VAR_W-1:0]  variable;
        logic [sat_types_pkg::LVL_W-1:0]  level;
        logic                             value;
        logic [sat_types_pkg::LVL_W-1:0]  index;
    } vt_write_t;

    // End of a backtrack, loaded into the height and level registers
    typedef struct packed {
        logic                             valid;
        logic [sat_types_pkg::LVL_W-1:0]  height;
        logic [sat_types_pkg::LVL_W-1:0]  level;
    } bt_commit_t;

endpackage

`default_nettype wire

// ==== hw/trail_manager.sv ====
/*
 * Assignment trail of the SAT solver, top level
 * Connects trail store, variable table, backtrack walker and arbiter
 */
`timescale 1ns/1ns
`default_nettype none

module trail_manager (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  push,
    input  logic [sat_types_pkg::VAR_W-1:0]       push_var,
    input  logic                                  push_value,
    input  logic [sat_types_pkg::LVL_W-1:0]       push_level,
    input  logic                                  push_is_decision,
    input  logic [sat_types_pkg::REASON_W-1:0]    push_reason,
    output logic [sat_types_pkg::LVL_W-1:0]       height,
    output logic [sat_types_pkg::LVL_W-1:0]       current_level,
    input  logic                                  backtrack_en,
    input  logic [sat_types_pkg::LVL_W-1:0]       backtrack_to_level,
    output logic                                  backtrack_done,
    output logic                                  backtrack_valid,
    output logic [sat_types_pkg::VAR_W-1:0]       backtrack_var,
    output logic                                  backtrack_value,
    output logic                                  backtrack_is_decision,
    input  logic [sat_types_pkg::VAR_W-1:0]       query_var,
    output logic [sat_types_pkg::LVL_W-1:0]       query_level,
    output logic                                  query_valid,
    output logic                                  query_value,
    input  logic [sat_types_pkg::LVL_W-1:0]       trail_read_idx,
    output logic [sat_types_pkg::VAR_W-1:0]       trail_read_var,
    output logic                                  trail_read_value,
    output logic [sat_types_pkg::LVL_W-1:0]       trail_read_level,
    output logic                                  trail_read_is_decision,
    output logic [sat_types_pkg::REASON_W-1:0]    trail_read_reason,
    output logic                                  push_lost
);

    sat_types_pkg::push_req_t        push_req;
    sat_types_pkg::push_req_t        push_grant;
    sat_types_pkg::trail_entry_t     read_entry;
    sat_types_pkg::trail_entry_t     peek_entry;
    sat_types_pkg::trail_entry_t     query_entry;
    trail_ctrl_pkg::vt_write_t       push_write;
    trail_ctrl_pkg::vt_write_t       clear_write;
    trail_ctrl_pkg::vt_write_t       table_write;
    trail_ctrl_pkg::bt_commit_t      commit;
    logic [sat_types_pkg::LVL_W-1:0] peek_idx;
    logic [sat_types_pkg::LVL_W-1:0] entry_idx;
    logic                            walker_busy;

    assign push_req = '{valid: push,
                        entry: '{variable: push_var, value: push_value, level: push_level,
                                 is_decision: push_is_decision, reason: push_reason}};

    var_table_arbiter u_arbiter (
        .push_req    (push_req),
        .walker_busy (walker_busy),
        .push_write  (push_write),
        .clear_write (clear_write),
        .push_grant  (push_grant),
        .table_write (table_write),
        .push_lost   (push_lost)
    );

    trail_store u_store (
        .clk           (clk),
        .reset         (reset),
        .push_in       (push_grant),
        .commit        (commit),
        .rd_a_idx      (trail_read_idx),
        .rd_b_idx      (peek_idx),
        .rd_c_idx      (entry_idx),
        .rd_a_entry    (read_entry),
        .rd_b_entry    (peek_entry),
        .rd_c_entry    (query_entry),
        .height        (height),
        .current_level (current_level),
        .push_write    (push_write)
    );

    var_table u_table (
        .clk           (clk),
        .wr            (table_write),
        .query_var     (query_var),
        .height        (height),
        .current_level (current_level),
        .trail_entry   (query_entry),
        .entry_idx     (entry_idx),
        .query_level   (query_level),
        .query_value   (query_value),
        .query_valid   (query_valid)
    );

    backtrack_walker u_walker (
        .clk                   (clk),
        .reset                 (reset),
        .backtrack_en          (backtrack_en),
        .backtrack_to_level    (backtrack_to_level),
        .height                (height),
        .peek_entry            (peek_entry),
        .peek_idx              (peek_idx),
        .backtrack_valid       (backtrack_valid),
        .backtrack_var         (backtrack_var),
        .backtrack_value       (backtrack_value),
        .backtrack_is_decision (backtrack_is_decision),
        .backtrack_done        (backtrack_done),
        .clear_write           (clear_write),
        .commit                (commit),
        .walker_busy           (walker_busy)
    );

    // External trail read, port A
    assign trail_read_var = read_entry.variable;
    assign trail_read_value = read_entry.value;
    assign trail_read_level = read_entry.level;
    assign trail_read_is_decision = read_entry.is_decision;
    assign trail_read_reason = read_entry.reason;

endmodule

`default_nettype wire

// ==== hw/trail_store.sv ====
/*
 * Trail RAM with height and current level registers
 * Push accept below the depth limit, commit from the backtrack walker
 * Three async read ports: A range-checked, B and C raw
 */
`timescale 1ns/1ns
`default_nettype none

module trail_store (
    input  logic                               clk,
    input  logic                               reset,
    input  sat_types_pkg::push_req_t           push_in,
    input  trail_ctrl_pkg::bt_commit_t         commit,
    input  logic [sat_types_pkg::LVL_W-1:0]    rd_a_idx,
    input  logic [sat_types_pkg::LVL_W-1:0]    rd_b_idx,
    input  logic [sat_types_pkg::LVL_W-1:0]    rd_c_idx,
    output sat_types_pkg::trail_entry_t        rd_a_entry,
    output sat_types_pkg::trail_entry_t        rd_b_entry,
    output sat_types_pkg::trail_entry_t        rd_c_entry,
    output logic [sat_types_pkg::LVL_W-1:0]    height,
    output logic [sat_types_pkg::LVL_W-1:0]    current_level,
    output trail_ctrl_pkg::vt_write_t          push_write
);

    sat_types_pkg::trail_entry_t trail [sat_types_pkg::MAX_VARS];

    logic [sat_types_pkg::LVL_W-1:0] height_q;
    logic [sat_types_pkg::LVL_W-1:0] level_q;
    logic                            push_ok;

    // Full trail drops the push
    assign push_ok = push_in.valid && (int'(height_q) < sat_types_pkg::MAX_VARS);

    assign height = height_q;
    assign current_level = level_q;

    // Commit and push never coincide, the arbiter holds pushes off
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            height_q <= '0;
            level_q <= '0;
        end else if (commit.valid) begin
            height_q <= commit.height;
            level_q <= commit.level;
        end else if (push_ok) begin
            height_q <= height_q + 1'b1;
            // A decision opens its level
            if (push_in.entry.is_decision) begin
                level_q <= push_in.entry.level;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            trail[height_q[sat_types_pkg::TRAIL_AW-1:0]] <= push_in.entry;
        end
    end

    // Variable table update for the slot just written
    always_comb begin
        push_write.valid = push_ok;
        push_write.variable = push_in.entry.variable;
        push_write.level = push_in.entry.level;
        push_write.value = push_in.entry.value;
        push_write.index = height_q;
    end

    // Port A hides entries above the height
    always_comb begin
        if (rd_a_idx < height_q) begin
            rd_a_entry = trail[rd_a_idx[sat_types_pkg::TRAIL_AW-1:0]];
        end else begin
            rd_a_entry = '0;
            rd_a_entry.reason = sat_types_pkg::NO_REASON;
        end
    end

    // Walker peek and query lookup
    assign rd_b_entry = trail[rd_b_idx[sat_types_pkg::TRAIL_AW-1:0]];
    assign rd_c_entry = trail[rd_c_idx[sat_types_pkg::TRAIL_AW-1:0]];

endmodule

`default_nettype wire

// ==== hw/var_table.sv ====
/*
 * Variable-indexed level, value and trail index tables
 * Stale-checked combinational query
 */
`timescale 1ns/1ns
`default_nettype none

module var_table (
    input  logic                               clk,
    input  trail_ctrl_pkg::vt_write_t          wr,
    input  logic [sat_types_pkg::VAR_W-1:0]    query_var,
    input  logic [sat_types_pkg::LVL_W-1:0]    height,
    input  logic [sat_types_pkg::LVL_W-1:0]    current_level,
    input  sat_types_pkg::trail_entry_t        trail_entry,
    output logic [sat_types_pkg::LVL_W-1:0]    entry_idx,
    output logic [sat_types_pkg::LVL_W-1:0]    query_level,
    output logic                               query_value,
    output logic                               query_valid
);

    // Slot 0 is never a real variable
    logic [sat_types_pkg::LVL_W-1:0] level_tab [sat_types_pkg::MAX_VARS + 1];
    logic                            value_tab [sat_types_pkg::MAX_VARS + 1];
    logic [sat_types_pkg::LVL_W-1:0] index_tab [sat_types_pkg::MAX_VARS + 1];

    logic [sat_types_pkg::VT_AW-1:0] wr_addr;
    logic [sat_types_pkg::VT_AW-1:0] q_addr;
    logic [sat_types_pkg::LVL_W-1:0] q_level;
    logic                            q_in_range;

    assign wr_addr = wr.variable[sat_types_pkg::VT_AW-1:0];
    assign q_addr = query_var[sat_types_pkg::VT_AW-1:0];

    always_ff @(posedge clk) begin
        if (wr.valid && wr.variable <= sat_types_pkg::MAX_VARS) begin
            level_tab[wr_addr] <= wr.level;
            value_tab[wr_addr] <= wr.value;
            index_tab[wr_addr] <= wr.index;
        end
    end

    assign q_in_range = (query_var != '0) && (query_var <= sat_types_pkg::MAX_VARS);
    assign q_level = level_tab[q_addr];

    // Trail slot looked up through store port C
    assign entry_idx = index_tab[q_addr];

    // Level above current means a backtracked assignment
    // Index or variable mismatch means the slot was reused
    assign query_valid = q_in_range
                         && (q_level != '0)
                         && (q_level <= current_level)
                         && (entry_idx < height)
                         && (trail_entry.variable == query_var);

    assign query_level = query_valid ? q_level : '0;
    assign query_value = query_valid && value_tab[q_addr];

endmodule

`default_nettype wire

// ==== hw/var_table_arbiter.sv ====
/*
 * Fixed-priority arbiter for the variable table write port
 * Walker wins, pushes during a walk are dropped and reported
 */
`timescale 1ns/1ns
`default_nettype none

module var_table_arbiter (
    input  sat_types_pkg::push_req_t           push_req,
    input  logic                               walker_busy,
    input  trail_ctrl_pkg::vt_write_t          push_write,
    input  trail_ctrl_pkg::vt_write_t          clear_write,
    output sat_types_pkg::push_req_t           push_grant,
    output trail_ctrl_pkg::vt_write_t          table_write,
    output logic                               push_lost
);

    // Whole push refused while the walker owns the trail
    always_comb begin
        push_grant = push_req;
        push_grant.valid = push_req.valid && !walker_busy;
    end

    assign push_lost = push_req.valid && walker_busy;

    // Clear has priority over the accepted-push write
    assign table_write = clear_write.valid ? clear_write : push_write;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the trail manager testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module trail_manager_tb -f all.f \
    -o trail_manager_sim || exit 1
out=$(./obj_dir/trail_manager_sim)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== include/trail_model.svh ====
/*
 * Reference model of the assignment trail for the testbench
 * Queue of live entries, current level
 * Expected push, query, read and backtrack results
 */
`ifndef TRAIL_MODEL_SVH
`define TRAIL_MODEL_SVH

sat_types_pkg::trail_entry_t     model_trail[$];
logic [sat_types_pkg::LVL_W-1:0] model_level = '0;

// Same drop rule as the DUT when full
function automatic void record_push(input sat_types_pkg::trail_entry_t e);
    if (model_trail.size() < sat_types_pkg::MAX_VARS) begin
        model_trail.push_back(e);
        if (e.is_decision) begin
            model_level = e.level;
        end
    end
endfunction

function automatic logic [sat_types_pkg::LVL_W-1:0] expected_height();
    return sat_types_pkg::LVL_W'(model_trail.size());
endfunction

// Newest live entry for the variable wins
function automatic bit lookup_assignment(input logic [sat_types_pkg::VAR_W-1:0] v,
                                         output logic [sat_types_pkg::LVL_W-1:0] lvl,
                                         output logic val);
    lvl = '0;
    val = 1'b0;
    for (int i = model_trail.size() - 1; i >= 0; i--) begin
        if (model_trail[i].variable == v) begin
            if (model_trail[i].level == '0 || model_trail[i].level > model_level) begin
                return 1'b0;
            end
            lvl = model_trail[i].level;
            val = model_trail[i].value;
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

function automatic sat_types_pkg::trail_entry_t entry_at(
        input logic [sat_types_pkg::LVL_W-1:0] idx);
    sat_types_pkg::trail_entry_t e;
    e = '0;
    e.reason = sat_types_pkg::NO_REASON;
    if (idx < model_trail.size()) begin
        e = model_trail[idx];
    end
    return e;
endfunction

// Removed entries come back newest first
function automatic void pop_above_level(input logic [sat_types_pkg::LVL_W-1:0] target,
                                        output sat_types_pkg::trail_entry_t removed[$]);
    removed = {};
    while (model_trail.size() > 0 && model_trail[$].level > target) begin
        removed.push_back(model_trail.pop_back());
    end
    model_level = target;
endfunction

`endif

// ==== tests/trail_manager_tb.sv ====
/*
 * Testbench for the trail manager
 * Clock, reset, random push and backtrack stimulus
 * Stream comparison process against the trail model
 * Per-test reporting and closing summary
 */
`timescale 1ns/1ns
`default_nettype none

module trail_manager_tb;

    `include "trail_model.svh"

    logic                                  clk = 1'b0;
    logic                                  reset;
    logic                                  push;
    logic [sat_types_pkg::VAR_W-1:0]       push_var;
    logic                                  push_value;
    logic [sat_types_pkg::LVL_W-1:0]       push_level;
    logic                                  push_is_decision;
    logic [sat_types_pkg::REASON_W-1:0]    push_reason;
    logic [sat_types_pkg::LVL_W-1:0]       height;
    logic [sat_types_pkg::LVL_W-1:0]       current_level;
    logic                                  backtrack_en;
    logic [sat_types_pkg::LVL_W-1:0]       backtrack_to_level;
    logic                                  backtrack_done;
    logic                                  backtrack_valid;
    logic [sat_types_pkg::VAR_W-1:0]       backtrack_var;
    logic                                  backtrack_value;
    logic                                  backtrack_is_decision;
    logic [sat_types_pkg::VAR_W-1:0]       query_var;
    logic [sat_types_pkg::LVL_W-1:0]       query_level;
    logic                                  query_valid;
    logic                                  query_value;
    logic [sat_types_pkg::LVL_W-1:0]       trail_read_idx;
    logic [sat_types_pkg::VAR_W-1:0]       trail_read_var;
    logic                                  trail_read_value;
    logic [sat_types_pkg::LVL_W-1:0]       trail_read_level;
    logic                                  trail_read_is_decision;
    logic [sat_types_pkg::REASON_W-1:0]    trail_read_reason;
    logic                                  push_lost;

    // Bookkeeping shared by the tasks and the stream monitor
    string                       test_name;
    int                          test_errors;
    int                          errors_total;
    int                          tests_run;
    int                          checks_run;
    int                          cycle_count;
    int                          en_cycle;
    int                          done_cycle;
    bit                          done_seen;
    bit                          var_used [0:sat_types_pkg::MAX_VARS];
    sat_types_pkg::trail_entry_t exp_stream[$];
    sat_types_pkg::trail_entry_t removed_last[$];
    sat_types_pkg::trail_entry_t stream_exp;

    trail_manager u_trail_manager (.*);

    // 8 ns period
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic compare_value(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
        checks_run++;
        assert (act === exp) else begin
            $display("mismatch %s %s: expected %0h, actual %0h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    // Removed entries arrive newest first and are compared as they appear
    always @(negedge clk) begin
        if (backtrack_valid === 1'b1) begin
            checks_run++;
            assert (exp_stream.size() != 0) else begin
                $display("error %s: backtrack_valid with no entry left to remove", test_name);
                test_errors++;
            end
            if (exp_stream.size() != 0) begin
                stream_exp = exp_stream.pop_front();
                compare_value("backtrack_var", 64'(stream_exp.variable), 64'(backtrack_var));
                compare_value("backtrack_value", 64'(stream_exp.value), 64'(backtrack_value));
                compare_value("backtrack_is_decision", 64'(stream_exp.is_decision),
                              64'(backtrack_is_decision));
            end
        end
        if (backtrack_done === 1'b1) begin
            done_cycle = cycle_count;
            done_seen = 1'b1;
        end
    end

    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        errors_total += test_errors;
        $display("test %s done, %0d errors", test_name, test_errors);
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout in %s while waiting for %s", test_name, what);
        $display("*** TEST FAILED ***");
        $finish;
    endtask

    task automatic check_state();
        @(negedge clk);
        compare_value("height", 64'(expected_height()), 64'(height));
        compare_value("current_level", 64'(model_level), 64'(current_level));
    endtask

    task automatic push_entry(input sat_types_pkg::trail_entry_t e);
        step_cycle();
        push = 1'b1;
        push_var = e.variable;
        push_value = e.value;
        push_level = e.level;
        push_is_decision = e.is_decision;
        push_reason = e.reason;
        // Walker is idle here, so nothing may be lost
        @(negedge clk);
        compare_value("push_lost", 64'd0, 64'(push_lost));
        step_cycle();
        push = 1'b0;
    endtask

    // Fresh variables only
    // The first push opens a new level
    task automatic push_random_entries(input int count);
        sat_types_pkg::trail_entry_t e;
        int v;
        for (int i = 0; i < count; i++) begin
            do begin
                v = int'($urandom_range(1, sat_types_pkg::MAX_VARS));
            end while (var_used[v]);
            var_used[v] = 1'b1;
            e.variable = 32'(v);
            e.value = 1'($urandom_range(0, 1));
            e.is_decision = (i == 0) || ($urandom_range(0, 3) == 0);
            e.level = e.is_decision ? model_level + 1'b1 : model_level;
            e.reason = e.is_decision ? '0 : 16'($urandom_range(1, 16'hfffe));
            push_entry(e);
            record_push(e);
            check_state();
        end
    endtask

    task automatic read_and_compare(input logic [sat_types_pkg::LVL_W-1:0] idx);
        sat_types_pkg::trail_entry_t e;
        step_cycle();
        trail_read_idx = idx;
        @(negedge clk);
        e = entry_at(idx);
        compare_value("trail_read_var", 64'(e.variable), 64'(trail_read_var));
        compare_value("trail_read_value", 64'(e.value), 64'(trail_read_value));
        compare_value("trail_read_level", 64'(e.level), 64'(trail_read_level));
        compare_value("trail_read_is_decision", 64'(e.is_decision),
                      64'(trail_read_is_decision));
        compare_value("trail_read_reason", 64'(e.reason), 64'(trail_read_reason));
    endtask

    task automatic query_and_compare(input logic [sat_types_pkg::VAR_W-1:0] v);
        logic [sat_types_pkg::LVL_W-1:0] lvl;
        logic                            val;
        bit                              exp_valid;
        step_cycle();
        query_var = v;
        @(negedge clk);
        exp_valid = lookup_assignment(v, lvl, val);
        // Unwritten table slots may read X and count as invalid
        compare_value("query_valid", 64'(exp_valid), 64'(query_valid === 1'b1));
        if (exp_valid) begin
            compare_value("query_level", 64'(lvl), 64'(query_level));
            compare_value("query_value", 64'(val), 64'(query_value));
        end
    endtask

    task automatic run_backtrack(input logic [sat_types_pkg::LVL_W-1:0] target,
                                 input bit push_during_walk);
        int k;
        int waited;
        pop_above_level(target, removed_last);
        exp_stream = removed_last;
        k = removed_last.size();
        done_seen = 1'b0;
        step_cycle();
        backtrack_en = 1'b1;
        backtrack_to_level = target;
        en_cycle = cycle_count;
        step_cycle();
        backtrack_en = 1'b0;
        // A push in the first WALK cycle is refused
        if (push_during_walk) begin
            push = 1'b1;
            push_var = 32'(sat_types_pkg::MAX_VARS);
            push_level = model_level + 1'b1;
            push_is_decision = 1'b1;
            @(negedge clk);
            compare_value("push_lost", 64'd1, 64'(push_lost));
            step_cycle();
            push = 1'b0;
        end
        waited = 0;
        while (!done_seen) begin
            @(posedge clk);
            waited++;
            if (waited > sat_types_pkg::MAX_VARS + 8) begin
                timeout_abort("backtrack_done");
            end
        end
        compare_value("done latency", 64'(k + 2), 64'(done_cycle - en_cycle));
        compare_value("entries left in stream", 64'd0, 64'(exp_stream.size()));
        check_state();
    endtask

    initial begin
        sat_types_pkg::trail_entry_t e;
        reset = 1'b1;
        push = 1'b0;
        push_var = '0;
        push_value = 1'b0;
        push_level = '0;
        push_is_decision = 1'b0;
        push_reason = '0;
        backtrack_en = 1'b0;
        backtrack_to_level = '0;
        query_var = '0;
        trail_read_idx = '0;
        cycle_count = 0;
        errors_total = 0;
        tests_run = 0;
        checks_run = 0;
        void'($urandom(32'he2c12db4));
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        start_test("reset_state");
        check_state();
        for (int i = 0; i < 8; i++) begin
            query_and_compare(32'($urandom_range(1, sat_types_pkg::MAX_VARS)));
        end
        finish_test();

        start_test("push_and_read");
        push_random_entries(40);
        for (int i = 0; i < int'(expected_height()) + 2; i++) begin
            read_and_compare(16'(i));
        end
        read_and_compare(16'hffff);
        finish_test();

        start_test("query");
        for (int i = 0; i < model_trail.size(); i++) begin
            query_and_compare(model_trail[i].variable);
        end
        query_and_compare(32'd0);
        query_and_compare(32'(sat_types_pkg::MAX_VARS + 1));
        query_and_compare(32'hffff_ffff);
        for (int v = 1; v <= sat_types_pkg::MAX_VARS; v += 17) begin
            if (!var_used[v]) begin
                query_and_compare(32'(v));
            end
        end
        finish_test();

        start_test("backtrack");
        run_backtrack(16'($urandom_range(0, int'(model_level) - 1)), 1'b0);
        for (int i = 0; i < removed_last.size(); i++) begin
            query_and_compare(removed_last[i].variable);
        end
        for (int i = 0; i < model_trail.size(); i++) begin
            query_and_compare(model_trail[i].variable);
        end
        finish_test();

        start_test("push_refused");
        push_random_entries(3);
        run_backtrack(model_level - 1'b1, 1'b1);
        // Empty the trail and then overfill it by one
        run_backtrack(16'd0, 1'b0);
        for (int i = 0; i <= sat_types_pkg::MAX_VARS; i++) begin
            e = '0;
            e.variable = 32'((i % sat_types_pkg::MAX_VARS) + 1);
            e.is_decision = (i == 0);
            e.level = 16'd1;
            push_entry(e);
            record_push(e);
        end
        check_state();
        compare_value("full height", 64'(sat_types_pkg::MAX_VARS), 64'(height));
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks_run, errors_total);
        if (errors_total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
